/* up_isa_pkg.sv */
package up_isa_pkg;

   localparam int OP_W = 4;

   // Data byte of an instruction sits in the upper memory half
   localparam logic DATA_TABLE_BIT = 1'b1;

   typedef enum logic [OP_W-1:0] {
      OP_HALT  = 4'h0,
      OP_LD0   = 4'h1,          // r0 from data table
      OP_LD1   = 4'h2,
      OP_LD2   = 4'h3,
      OP_LD3   = 4'h4,
      OP_ADD   = 4'h5,          // r1 = r1 op r2
      OP_SUB   = 4'h6,
      OP_MUL   = 4'h7,
      OP_NAND  = 4'h8,
      OP_XOR   = 4'h9,
      OP_MOV32 = 4'hA,          // r3 = r2
      OP_OUT   = 4'hB,
      OP_SKEQ  = 4'hC,          // Skip next nibble if r1 == r2
      OP_NOP_D = 4'hD,
      OP_NOP_E = 4'hE,
      OP_NOP_F = 4'hF
   } isa_op_e;

endpackage

/* up_uop_pkg.sv */
package up_uop_pkg;

   // Datapath mux select, unlisted codes give a zero address
   typedef enum logic [4:0] {
      UOP_ADD       = 5'b00000,
      UOP_SUB       = 5'b00001,
      UOP_MUL       = 5'b00010,
      UOP_NAND      = 5'b00011,
      UOP_XOR12     = 5'b00101,
      UOP_PC_BYTE   = 5'b10100,  // Fetch byte address
      UOP_PC_INC    = 5'b10101,
      UOP_R3        = 5'b10110,
      UOP_R2        = 5'b11100,
      UOP_DATA_BYTE = 5'b11110,  // Data table address
      UOP_PASS      = 5'b11111
   } uop_e;

   // Bit 2 picks the source, bits 1:0 the register
   typedef enum logic [2:0] {
      SEL_I0 = 3'b000,
      SEL_I1 = 3'b001,
      SEL_I2 = 3'b010,
      SEL_I3 = 3'b011,
      SEL_O0 = 3'b100,
      SEL_O1 = 3'b101,
      SEL_O2 = 3'b110,
      SEL_O3 = 3'b111
   } rb_sel_e;

   typedef enum logic [2:0] {IDLE, FETCH, STEP, EXEC, OUT_WAIT} ctrl_state_e;

endpackage

/* up_datapath.sv */
`timescale 1ns/10ps

module up_datapath
   import up_isa_pkg::*;
   import up_uop_pkg::*;
#(
   parameter logic [7:0] PC_RESET = 8'h08
) (
   input  logic        clk,
   input  logic        nRst,
   input  logic [7:0]  data_in,
   input  uop_e        op,
   input  logic        ir_we,
   input  logic        pc_we,
   input  logic        rb_we,
   input  rb_sel_e     rb_sel,
   output logic [7:0]  data_out,
   output isa_op_e     ir,
   output logic        z,
   output logic [7:0]  r3_out
);

   logic [7:0]      pc;                 // Nibble address
   logic [7:0]      rf [4];             // r0 to r3
   logic [7:0]      r1;
   logic [7:0]      r2;
   logic [7:0]      r3;
   logic [OP_W-1:0] nibble;

   assign r1     = rf[1];
   assign r2     = rf[2];
   assign r3     = rf[3];
   assign r3_out = r3;
   assign z      = (r1 == r2);

   // Even pc takes the high half of the byte
   assign nibble = pc[0] ? data_in[3:0] : data_in[7:4];

   always_comb begin
      case (op)
         UOP_ADD:       data_out = r1 + r2;
         UOP_SUB:       data_out = r1 - r2;
         UOP_MUL:       data_out = r1 * r2;     // Low byte only
         UOP_NAND:      data_out = ~(r1 & r2);
         UOP_XOR12:     data_out = r1 ^ r2;
         UOP_PC_BYTE:   data_out = {1'b0, pc[7:1]};
         UOP_PC_INC:    data_out = pc + 8'd1;
         UOP_R3:        data_out = r3;
         UOP_R2:        data_out = r2;
         UOP_DATA_BYTE: data_out = {DATA_TABLE_BIT, pc[7:1]};
         default:       data_out = 8'h00;       // Idle address
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RESET;
         ir <= OP_HALT;
         for (int i = 0; i < 4; i++) begin
            rf[i] <= 8'h00;
         end
      end else begin
         if (pc_we) begin
            pc <= data_out;
         end
         if (ir_we) begin
            ir <= isa_op_e'(nibble);
         end
         if (rb_we) begin
            rf[rb_sel[1:0]] <= rb_sel[2] ? data_out : data_in;  // O codes take mux result
         end
      end
   end

endmodule

/* up_control.sv */
`timescale 1ns/10ps

module up_control
   import up_isa_pkg::*;
   import up_uop_pkg::*;
(
   input  logic        clk,
   input  logic        nRst,
   input  logic        start,
   input  isa_op_e     ir,
   input  logic        z,
   input  logic        out_ready,
   output uop_e        op,
   output logic        ir_we,
   output logic        pc_we,
   output logic        rb_we,
   output rb_sel_e     rb_sel,
   output logic        out_valid,
   output logic        running,
   output logic        halted,
   output logic        idle
);

   ctrl_state_e state;
   ctrl_state_e state_nxt;

   function automatic uop_e alu_uop(input isa_op_e opc);
      case (opc)
         OP_SUB:  return UOP_SUB;
         OP_MUL:  return UOP_MUL;
         OP_NAND: return UOP_NAND;
         OP_XOR:  return UOP_XOR12;
         default: return UOP_ADD;
      endcase
   endfunction

   function automatic rb_sel_e ld_target(input isa_op_e opc);
      case (opc)
         OP_LD1:  return SEL_I1;
         OP_LD2:  return SEL_I2;
         OP_LD3:  return SEL_I3;
         default: return SEL_I0;
      endcase
   endfunction

   always_comb begin
      state_nxt = state;
      op        = UOP_PASS;
      ir_we     = 1'b0;
      pc_we     = 1'b0;
      rb_we     = 1'b0;
      rb_sel    = SEL_I0;
      case (state)
         IDLE: begin
            if (start) begin
               state_nxt = FETCH;
            end
         end
         FETCH: begin
            op        = UOP_PC_BYTE;
            ir_we     = 1'b1;
            state_nxt = STEP;
         end
         STEP: begin
            op        = UOP_PC_INC;
            pc_we     = 1'b1;
            state_nxt = EXEC;
         end
         EXEC: begin
            state_nxt = FETCH;
            case (ir)
               OP_HALT: state_nxt = IDLE;
               OP_LD0, OP_LD1, OP_LD2, OP_LD3: begin
                  op     = UOP_DATA_BYTE;
                  rb_we  = 1'b1;
                  rb_sel = ld_target(ir);
               end
               OP_ADD, OP_SUB, OP_MUL, OP_NAND, OP_XOR: begin
                  op     = alu_uop(ir);
                  rb_we  = 1'b1;
                  rb_sel = SEL_O1;
               end
               OP_MOV32: begin
                  op     = UOP_R2;
                  rb_we  = 1'b1;
                  rb_sel = SEL_O3;
               end
               OP_OUT: begin
                  op        = UOP_R3;
                  state_nxt = OUT_WAIT;
               end
               OP_SKEQ: begin
                  if (z) begin
                     op    = UOP_PC_INC;          // Step over next nibble
                     pc_we = 1'b1;
                  end
               end
               default: ;                          // D to F
            endcase
         end
         OUT_WAIT: begin
            op = UOP_R3;
            if (out_ready) begin
               state_nxt = FETCH;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state  <= IDLE;
         halted <= 1'b0;
      end else begin
         state  <= state_nxt;
         halted <= (state == EXEC) && (ir == OP_HALT);  // One cycle, lands with IDLE
      end
   end

   assign out_valid = (state == OUT_WAIT);
   assign idle      = (state == IDLE);
   assign running   = (state != IDLE);

endmodule

/* up_memory.sv */
`timescale 1ns/10ps

module up_memory (
   input  logic        clk,
   input  logic        nRst,
   input  logic [7:0]  addr,
   input  logic        load_valid,
   input  logic [7:0]  load_addr,
   input  logic [7:0]  load_data,
   input  logic        idle,
   output logic [7:0]  rdata,
   output logic        load_ready
);

   logic [7:0] mem [256];
   logic       wr_pend;                  // Staged load byte waiting for the array
   logic [7:0] wr_addr;
   logic [7:0] wr_data;

   assign load_ready = idle;

   // Forward a staged byte that has not reached the array yet
   assign rdata = (wr_pend && (wr_addr == addr)) ? wr_data : mem[addr];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         wr_pend <= 1'b0;
      end else begin
         wr_pend <= load_valid && load_ready;
      end
   end

   always_ff @(posedge clk) begin
      if (load_valid && load_ready) begin
         wr_addr <= load_addr;
         wr_data <= load_data;
      end
      if (wr_pend) begin
         mem[wr_addr] <= wr_data;
      end
   end

endmodule

/* up_core.sv */
`timescale 1ns/10ps

module up_core
   import up_isa_pkg::*;
   import up_uop_pkg::*;
#(
   parameter logic [7:0] PC_RESET = 8'h08
) (
   input  logic        clk,
   input  logic        nRst,
   input  logic        start,
   input  logic        load_valid,
   output logic        load_ready,
   input  logic [7:0]  load_addr,
   input  logic [7:0]  load_data,
   output logic        out_valid,
   input  logic        out_ready,
   output logic [7:0]  out_data,
   output logic        running,
   output logic        halted
);

   uop_e       op;
   rb_sel_e    rb_sel;
   isa_op_e    ir;
   logic       ir_we;
   logic       pc_we;
   logic       rb_we;
   logic       z;
   logic       idle;
   logic [7:0] bus;                      // Mux result, also the memory address
   logic [7:0] mem_data;

   up_control u_control (
      .clk       (clk),
      .nRst      (nRst),
      .start     (start),
      .ir        (ir),
      .z         (z),
      .out_ready (out_ready),
      .op        (op),
      .ir_we     (ir_we),
      .pc_we     (pc_we),
      .rb_we     (rb_we),
      .rb_sel    (rb_sel),
      .out_valid (out_valid),
      .running   (running),
      .halted    (halted),
      .idle      (idle)
   );

   up_datapath #(
      .PC_RESET (PC_RESET)
   ) u_datapath (
      .clk      (clk),
      .nRst     (nRst),
      .data_in  (mem_data),
      .op       (op),
      .ir_we    (ir_we),
      .pc_we    (pc_we),
      .rb_we    (rb_we),
      .rb_sel   (rb_sel),
      .data_out (bus),
      .ir       (ir),
      .z        (z),
      .r3_out   (out_data)
   );

   up_memory u_memory (
      .clk        (clk),
      .nRst       (nRst),
      .addr       (bus),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .idle       (idle),
      .rdata      (mem_data),
      .load_ready (load_ready)
   );

endmodule

/* up_checker.sv */
`timescale 1ns/10ps

module up_checker (
   input  logic        clk,
   input  logic        nRst,
   input  logic        out_valid,
   input  logic        out_ready,
   input  logic [7:0]  out_data,
   input  logic        halted,
   input  logic        running,
   input  logic        load_ready
);

   logic [7:0] exp_mem [256];
   int         n_exp       = 0;        // Expected bytes queued so far
   int         rx_count    = 0;
   int         halt_count  = 0;
   int         obs_errors  = 0;
   int         last_errors = 0;
   int         last_halts  = 0;
   int         n_done      = 0;
   int         pass_count  = 0;
   int         fail_count  = 0;
   logic       stall_valid = 1'b0;
   logic [7:0] stall_data  = 8'h00;

   always @(posedge clk) begin
      if (nRst) begin
         if (load_ready !== !running) begin
            $display("[FAIL] load_ready: expected %h, got %h", !running, load_ready);
            obs_errors++;
         end
         if (stall_valid && !out_valid) begin
            $display("out_valid dropped before the byte was accepted");
            obs_errors++;
         end
         if (stall_valid && out_valid && (out_data != stall_data)) begin
            $display("[FAIL] out_data changed while stalled: held %h, now %h",
                     stall_data, out_data);
            obs_errors++;
         end
         if (out_valid && out_ready) begin
            if (rx_count >= n_exp) begin
               $display("Unexpected extra output byte %h", out_data);
               obs_errors++;
            end else if (out_data !== exp_mem[8'(rx_count)]) begin
               $display("[FAIL] out_data: expected %h, got %h",
                        exp_mem[8'(rx_count)], out_data);
               obs_errors++;
            end
            rx_count++;
         end
         stall_valid = out_valid && !out_ready;
         stall_data  = out_data;
         if (halted) begin
            halt_count++;
         end
      end
   end

   task automatic push_expected(input logic [7:0] b);
      exp_mem[8'(n_exp)] = b;
      n_exp++;
   endtask

   task automatic end_test();
      int errs;
      errs = obs_errors - last_errors;
      if (rx_count < n_exp) begin
         $display("Test %0d: %0d expected output bytes never arrived", n_done, n_exp - rx_count);
         errs++;
      end
      if (halt_count != last_halts + 1) begin
         $display("Test %0d: halted did not pulse exactly once", n_done);
         errs++;
      end
      if (running) begin
         $display("Test %0d: core still running after halt", n_done);
         errs++;
      end
      last_errors = obs_errors;
      last_halts  = halt_count;
      if (errs == 0) begin
         pass_count++;
         $display("Test %0d: PASS", n_done);
      end else begin
         fail_count++;
         $display("Test %0d: FAIL (%0d errors)", n_done, errs);
      end
      n_done++;
   endtask

   task automatic report();
      $display("Tests run: %0d, passed: %0d, failed: %0d", n_done, pass_count, fail_count);
   endtask

endmodule

/* tb_up_core.sv */
`timescale 1ns/10ps

module tb_up_core;

   logic       clk;
   logic       nRst;
   logic       start;
   logic       load_valid;
   logic       load_ready;
   logic [7:0] load_addr;
   logic [7:0] load_data;
   logic       out_valid;
   logic       out_ready;
   logic [7:0] out_data;
   logic       running;
   logic       halted;
   string      lines[$];
   int         n_tests = 0;

   up_core #(
      .PC_RESET (8'h08)
   ) u_up_core (
      .clk        (clk),
      .nRst       (nRst),
      .start      (start),
      .load_valid (load_valid),
      .load_ready (load_ready),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .running    (running),
      .halted     (halted)
   );

   up_checker u_checker (
      .clk        (clk),
      .nRst       (nRst),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .halted     (halted),
      .running    (running),
      .load_ready (load_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Random back-pressure, about one cycle in four
   initial begin
      out_ready = 1'b1;
      void'($urandom(88771));
      forever begin
         @(negedge clk);
         out_ready = ($urandom % 4) != 0;
      end
   end

   initial begin
      wait (n_tests > 0);
      repeat (n_tests * 400) @(posedge clk);
      $display("Timeout after %0d cycles, the core did not finish", n_tests * 400);
      $display("Some tests failed");
      $finish;
   end

   task automatic load_byte(input logic [7:0] a, input logic [7:0] d);
      logic ok;
      load_addr  = a;
      load_data  = d;
      load_valid = 1'b1;
      do begin
         ok = load_ready;                 // Stable until the next rising edge
         @(negedge clk);
      end while (!ok);
   endtask

   task automatic run_program();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (!halted) @(negedge clk);
      @(negedge clk);                     // Let the checker see the halt pulse
   endtask

   initial begin
      string      line;
      logic [7:0] a;
      logic [7:0] d [8];
      logic [7:0] e;
      int         fd;
      int         r;
      int         n_h;
      logic       go;
      start      = 1'b0;
      load_valid = 1'b0;
      load_addr  = 8'h00;
      load_data  = 8'h00;
      nRst       = 1'b0;
      n_h        = 0;
      go         = 1'b0;
      fd = $fopen("up_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open up_patterns.txt");
         $display("Some tests failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 0 && line.len() > 0 && line[0] != "#") begin
               lines.push_back(line);
               if (line[0] == "H") n_h++;
            end
         end
         $fclose(fd);
         n_tests = n_h;
         repeat (10) @(negedge clk);
         nRst = 1'b1;
         @(negedge clk);
         foreach (lines[i]) begin
            case (lines[i][0])
               "L": begin
                  r = $sscanf(lines[i], "L %h %h %h %h %h %h %h %h %h",
                              a, d[0], d[1], d[2], d[3], d[4], d[5], d[6], d[7]);
                  foreach (d[k]) begin
                     load_byte(a + 8'(k), d[k]);
                  end
                  load_valid = 1'b0;
               end
               "E": begin
                  r = $sscanf(lines[i], "E %h", e);
                  u_checker.push_expected(e);
               end
               "S": go = 1'b1;
               "H": begin
                  if (go) run_program();
                  go = 1'b0;
                  u_checker.end_test();
               end
               default: ;
            endcase
         end
         u_checker.report();
         if (n_tests > 0 && u_checker.fail_count == 0 && u_checker.pass_count == n_tests) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

endmodule

/* up_core.f */
up_isa_pkg.sv
up_uop_pkg.sv
up_datapath.sv
up_control.sv
up_memory.sv
up_core.sv
up_checker.sv
tb_up_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_up_core -f up_core.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

out=$(./obj_dir/Vtb_up_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed"; then
   exit 0
else
   exit 1
fi

/* up_patterns.txt */
# L addr b0..b7 loads eight bytes from addr; S starts the core
# E byte is one expected output in order; H waits for halt and ends the test
# Test 1: LD2, MOV32, OUT, HALT from nibble 8
L 04 3A B0 00 00 00 00 00 00
L 84 5C 00 00 00 00 00 00 00
S
E 5C
H
# Test 2: ADD SUB MUL NAND XOR, each checked by SKEQ over an OUT
L 06 4D 2D 35 3C BD 36 3C BD
L 0E 37 3C BD 38 3C BD 39 3C
L 16 BD B0 00 00 00 00 00 00
L 86 EE 90 85 15 00 20 F5 00
L 8E 13 2F 00 F0 DF 00 5A 85
S
E EE
H
# Test 3: SKEQ taken and not taken, several outputs under back-pressure
L 18 2C BA BD 3A CB 4B B0 00
L 98 11 00 00 11 00 7E 00 00
S
E EE
E 85
E 7E
E 7E
H
# Test 4: reload after halt
L 1F 3A B0 00 00 00 00 00 00
L 9F C3 00 00 00 00 00 00 00
S
E C3
H
